// File: Bender.yml
package:
  name: femto_core

sources:
  - source/femtoPkg.sv
  - source/decodeIf.sv
  - source/instrDecoder.sv
  - source/regFile.sv
  - source/aluExecute.sv
  - source/memAlign.sv
  - source/coreControl.sv
  - source/femtoCore.sv
  - target: test
    files:
      - tests/clockGen.sv
      - tests/femtoCoreSva.sv
      - tests/femtoCoreTb.sv

// File: flist.f
source/femtoPkg.sv
source/decodeIf.sv
source/instrDecoder.sv
source/regFile.sv
source/aluExecute.sv
source/memAlign.sv
source/coreControl.sv
source/femtoCore.sv
tests/clockGen.sv
tests/femtoCoreSva.sv
tests/femtoCoreTb.sv

// File: source/aluExecute.sv
`timescale 1ns/1ps

module aluExecute import femtoPkg::*; (
   input  logic            clk,
   input  logic            aluStart,    // Operands valid in this cycle
   input  logic [xlen-1:0] rs1Data,
   input  logic [xlen-1:0] rs2Data,
   decodeIf.consumer       dec,
   output logic [xlen-1:0] aluSum,      // Address and JALR target
   output logic [xlen-1:0] aluResult,
   output logic            aluBusy,     // Shift in progress
   output logic            predicate    // Branch taken
);

   localparam int shamtWidth = $clog2(xlen);

   logic [xlen-1:0]       aluIn2;
   logic [xlen:0]         aluMinus;     // Carry out gives unsigned compare
   logic                  lt;
   logic                  ltu;
   logic                  eq;
   logic [xlen-1:0]       aluReg;       // Result and shift register
   logic [shamtWidth-1:0] shamt = '0;   // Remaining shift steps

   // Second operand by instruction class
   assign aluIn2 = (dec.isAluReg | dec.isBranch) ? rs2Data :
                   dec.isStore                   ? dec.immS : dec.immI;

   assign aluSum   = rs1Data + aluIn2;
   assign aluMinus = {1'b1, ~aluIn2} + {1'b0, rs1Data} + (xlen+1)'(1);

   // Signed compare falls back to the sign bits when they differ
   assign lt  = (rs1Data[xlen-1] ^ aluIn2[xlen-1]) ? rs1Data[xlen-1] : aluMinus[xlen];
   assign ltu = aluMinus[xlen];
   assign eq  = (aluMinus[xlen-1:0] == '0);

   // ******************************
   always_ff @(posedge clk) begin
      if (aluStart) begin
         case (dec.funct3)
            3'b000: aluReg <= (dec.altOp & dec.regOp) ? aluMinus[xlen-1:0] : aluSum;
            3'b010: aluReg <= {{(xlen-1){1'b0}}, lt};    // SLT
            3'b011: aluReg <= {{(xlen-1){1'b0}}, ltu};   // SLTU
            3'b100: aluReg <= rs1Data ^ aluIn2;
            3'b110: aluReg <= rs1Data | aluIn2;
            3'b111: aluReg <= rs1Data & aluIn2;
            3'b001, 3'b101: begin
               aluReg <= rs1Data;                   // Shift starts from rs1
               shamt  <= aluIn2[shamtWidth-1:0];
            end
         endcase
      end else if (aluBusy) begin
         shamt  <= shamt - 1'b1;
         // Right shifts fill with the sign only for SRA
         aluReg <= dec.funct3[2] ? {dec.altOp & aluReg[xlen-1], aluReg[xlen-1:1]} :
                                   aluReg << 1;
      end
   end

   assign aluBusy   = |shamt;
   assign aluResult = aluReg;

   // ******************************
   // Branch condition registered every cycle
   always_ff @(posedge clk) begin
      case (dec.funct3)
         3'b000:  predicate <= eq;     // BEQ
         3'b001:  predicate <= !eq;    // BNE
         3'b100:  predicate <= lt;     // BLT
         3'b101:  predicate <= !lt;    // BGE
         3'b110:  predicate <= ltu;    // BLTU
         3'b111:  predicate <= !ltu;   // BGEU
         default: predicate <= 1'b0;
      endcase
   end

endmodule

// File: source/coreControl.sv
`timescale 1ns/1ps

module coreControl import femtoPkg::*; #(
   parameter logic [xlen-1:0] resetAddr = '0,
   parameter int              addrWidth = 24
) (
   input  logic                 clk,
   input  logic                 reset,
   input  logic                 memRBusy,
   input  logic                 memWBusy,
   input  logic [xlen-1:0]      aluSum,
   input  logic                 aluBusy,
   input  logic                 predicate,
   decodeIf.consumer            dec,
   output logic [addrWidth-1:0] addr,        // Memory address register
   output logic [xlen-1:0]      pcPlusImm,
   output logic [xlen-1:0]      pcPlus4,
   output coreState             state,
   output logic                 memRead,
   output logic                 instrLoad,
   output logic                 aluStart,
   output logic                 wbEnable
);

   logic [addrWidth-1:0] pc;
   logic [addrWidth-1:0] pcInc;
   logic [xlen-1:0]      immSel;
   logic                 jumpToImm;   // JAL or taken branch

   // ******************************
   // Program counter arithmetic
   assign pcInc   = pc + addrWidth'(4);
   assign pcPlus4 = xlen'(pcInc);

   // One adder for JAL and branch targets and AUIPC
   assign immSel    = dec.isJal ? dec.immJ : (dec.isAuipc ? dec.immU : dec.immB);
   assign pcPlusImm = xlen'(pc) + immSel;
   assign jumpToImm = dec.isJal | (dec.isBranch & predicate);

   // ******************************
   // FSM
   always_ff @(posedge clk) begin
      if (!reset) begin
         state <= waitAluOrMem;               // Waits for idle memory
         pc    <= resetAddr[addrWidth-1:0];
      end else begin
         unique case (state)
            fetchInstr: state <= waitInstr;
            waitInstr: begin
               if (!memRBusy) begin
                  state <= fetchRegs;         // Instruction latched now
               end
            end
            fetchRegs: state <= alu;
            alu: state <= execute;
            execute: begin
               pc <= dec.isJalr ? aluSum[addrWidth-1:0] :
                     jumpToImm  ? pcPlusImm[addrWidth-1:0] : pcInc;
               // Next fetch address or the data address
               addr <= (dec.isJalr | dec.isLoad | dec.isStore) ? aluSum[addrWidth-1:0] :
                       jumpToImm ? pcPlusImm[addrWidth-1:0] : pcInc;
               if (dec.isLoad) begin
                  state <= load;
               end else if (dec.isStore) begin
                  state <= store;
               end else if (aluBusy) begin
                  state <= waitAluOrMem;      // Serial shift
               end else begin
                  state <= fetchInstr;
               end
            end
            load, store: state <= waitAluOrMem;
            waitAluOrMem: begin
               if (!aluBusy && !memRBusy && !memWBusy) begin
                  addr  <= pc;
                  state <= fetchInstr;
               end
            end
            default: state <= waitAluOrMem;
         endcase
      end
   end

   // ******************************
   // Strobes decoded from the state
   assign memRead   = (state == fetchInstr) | (state == load);
   assign instrLoad = (state == waitInstr) & !memRBusy;
   assign aluStart  = (state == alu) & (dec.isAluImm | dec.isAluReg);
   assign wbEnable  = !(dec.isBranch | dec.isStore) &
                      ((state == execute) | (state == waitAluOrMem));

endmodule

// File: source/decodeIf.sv
`timescale 1ns/1ps

interface decodeIf
   import femtoPkg::*;
();

   // Opcode class flags
   logic isLoad, isAluImm, isAuipc, isStore, isAluReg;
   logic isLui, isBranch, isJalr, isJal;

   logic [regAddrWidth-1:0] rd, rs1, rs2;   // Register indices
   logic [2:0]              funct3;
   logic                    altOp;          // Bit 30 selects SUB and SRA
   logic                    regOp;          // Bit 5 marks register form

   // Sign-extended immediates
   logic [xlen-1:0] immI, immS, immB, immU, immJ;

   modport decoder (
      output isLoad, isAluImm, isAuipc, isStore, isAluReg, isLui, isBranch, isJalr, isJal,
      output rd, rs1, rs2, funct3, altOp, regOp, immI, immS, immB, immU, immJ
   );

   modport consumer (
      input isLoad, isAluImm, isAuipc, isStore, isAluReg, isLui, isBranch, isJalr, isJal,
      input rd, rs1, rs2, funct3, altOp, regOp, immI, immS, immB, immU, immJ
   );

endinterface

// File: source/femtoCore.sv
`timescale 1ns/1ps

module femtoCore import femtoPkg::*; #(
   parameter logic [xlen-1:0] resetAddr = '0,
   parameter int              addrWidth = 24   // 16 to 32
) (
   input  logic            clk,
   input  logic            reset,
   output logic [xlen-1:0] memAddr,
   output logic [xlen-1:0] memWData,
   output logic [3:0]      memWMask,    // Byte lanes to write
   input  logic [xlen-1:0] memRData,    // Instructions and data
   output logic            memRead,     // One-cycle read strobe
   input  logic            memRBusy,
   input  logic            memWBusy
);

   logic [addrWidth-1:0] addr;
   logic [xlen-1:0]      rs1Data;
   logic [xlen-1:0]      rs2Data;
   logic [xlen-1:0]      aluSum;
   logic [xlen-1:0]      aluResult;
   logic [xlen-1:0]      wbData;
   logic [xlen-1:0]      pcPlusImm;
   logic [xlen-1:0]      pcPlus4;
   logic                 aluBusy;
   logic                 predicate;
   logic                 instrLoad;
   logic                 aluStart;
   logic                 wbEnable;
   coreState             state;

   decodeIf dec ();

   assign memAddr = xlen'(addr);   // Zero-padded upper bits

   // ******************************
   instrDecoder decoder0 (
      .clk(clk), .instrLoad(instrLoad), .memRData(memRData), .dec(dec.decoder)
   );

   regFile regs0 (
      .clk(clk), .rs1(dec.rs1), .rs2(dec.rs2), .rd(dec.rd),
      .wbEnable(wbEnable), .wbData(wbData), .rs1Data(rs1Data), .rs2Data(rs2Data)
   );

   aluExecute alu0 (
      .clk(clk), .aluStart(aluStart), .rs1Data(rs1Data), .rs2Data(rs2Data),
      .dec(dec.consumer), .aluSum(aluSum), .aluResult(aluResult),
      .aluBusy(aluBusy), .predicate(predicate)
   );

   memAlign align0 (
      .addrLow(addr[1:0]), .state(state), .memRData(memRData), .rs2Data(rs2Data),
      .aluResult(aluResult), .pcPlusImm(pcPlusImm), .pcPlus4(pcPlus4),
      .dec(dec.consumer), .memWData(memWData), .memWMask(memWMask), .wbData(wbData)
   );

   coreControl #(
      .resetAddr(resetAddr),
      .addrWidth(addrWidth)
   ) control0 (
      .clk(clk), .reset(reset), .memRBusy(memRBusy), .memWBusy(memWBusy),
      .aluSum(aluSum), .aluBusy(aluBusy), .predicate(predicate), .dec(dec.consumer),
      .addr(addr), .pcPlusImm(pcPlusImm), .pcPlus4(pcPlus4), .state(state),
      .memRead(memRead), .instrLoad(instrLoad), .aluStart(aluStart), .wbEnable(wbEnable)
   );

endmodule

// File: source/femtoPkg.sv
package femtoPkg;

   localparam int xlen = 32;           // Data word width
   localparam int regAddrWidth = 5;    // Register index width

   // ******************************
   // Major opcodes from instruction bits 6 to 2
   localparam logic [4:0] opLoad   = 5'b00000;   // rd <- mem[rs1 + immI]
   localparam logic [4:0] opAluImm = 5'b00100;   // rd <- rs1 op immI
   localparam logic [4:0] opAuipc  = 5'b00101;   // rd <- pc + immU
   localparam logic [4:0] opStore  = 5'b01000;   // mem[rs1 + immS] <- rs2
   localparam logic [4:0] opAluReg = 5'b01100;   // rd <- rs1 op rs2
   localparam logic [4:0] opLui    = 5'b01101;   // rd <- immU
   localparam logic [4:0] opBranch = 5'b11000;   // Conditional pc + immB
   localparam logic [4:0] opJalr   = 5'b11001;   // rd <- pc + 4 and jump to rs1 + immI
   localparam logic [4:0] opJal    = 5'b11011;   // rd <- pc + 4 and jump to pc + immJ

   // Access size in funct3 bits 1 to 0
   localparam logic [1:0] sizeByte = 2'b00;
   localparam logic [1:0] sizeHalf = 2'b01;

   // ******************************
   // One-hot FSM states
   typedef enum logic [7:0] {
      fetchInstr   = 8'b0000_0001,  // Address out and instruction in flight
      waitInstr    = 8'b0000_0010,  // Latch instruction once memory is ready
      fetchRegs    = 8'b0000_0100,  // Register values in flight
      execute      = 8'b0000_1000,  // Crossroads of all instruction classes
      load         = 8'b0001_0000,  // Data address out and read strobe
      waitAluOrMem = 8'b0010_0000,  // Wait for shifter or memory
      store        = 8'b0100_0000,  // Write mask active for one cycle
      alu          = 8'b1000_0000   // Operands valid and ALU started
   } coreState;

   // ******************************
   // Instruction formats over one word
   typedef struct packed {
      logic [6:0] funct7;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] rd;
      logic [6:0] opcode;
   } rFormat;

   typedef struct packed {
      logic [11:0] imm;
      logic [4:0]  rs1;
      logic [2:0]  funct3;
      logic [4:0]  rd;
      logic [6:0]  opcode;
   } iFormat;

   typedef struct packed {
      logic [6:0] immHi;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] immLo;
      logic [6:0] opcode;
   } sFormat;

   typedef struct packed {
      logic       imm12;
      logic [5:0] imm10to5;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [3:0] imm4to1;
      logic       imm11;
      logic [6:0] opcode;
   } bFormat;

   typedef struct packed {
      logic [19:0] imm;
      logic [4:0]  rd;
      logic [6:0]  opcode;
   } uFormat;

   typedef struct packed {
      logic       imm20;
      logic [9:0] imm10to1;
      logic       imm11;
      logic [7:0] imm19to12;
      logic [4:0] rd;
      logic [6:0] opcode;
   } jFormat;

   typedef union packed {
      rFormat rType;
      iFormat iType;
      sFormat sType;
      bFormat bType;
      uFormat uType;
      jFormat jType;
   } instrWord;

endpackage

// File: source/instrDecoder.sv
`timescale 1ns/1ps

module instrDecoder import femtoPkg::*; (
   input  logic            clk,
   input  logic            instrLoad,   // Latch strobe from the FSM
   input  logic [xlen-1:0] memRData,
   decodeIf.decoder        dec
);

   instrWord   instr;    // Latched instruction word
   logic [4:0] opClass;

   always_ff @(posedge clk) begin
      if (instrLoad) begin
         instr <= memRData;
      end
   end

   assign opClass = instr.rType.opcode[6:2];   // Bits 1 to 0 are always 11

   // Class flags settle one cycle after the latch
   always_ff @(posedge clk) begin
      dec.isLoad   <= (opClass == opLoad);
      dec.isAluImm <= (opClass == opAluImm);
      dec.isAuipc  <= (opClass == opAuipc);
      dec.isStore  <= (opClass == opStore);
      dec.isAluReg <= (opClass == opAluReg);
      dec.isLui    <= (opClass == opLui);
      dec.isBranch <= (opClass == opBranch);
      dec.isJalr   <= (opClass == opJalr);
      dec.isJal    <= (opClass == opJal);
   end

   // ******************************
   // Fields through the R view
   assign dec.rd     = instr.rType.rd;
   assign dec.rs1    = instr.rType.rs1;
   assign dec.rs2    = instr.rType.rs2;
   assign dec.funct3 = instr.rType.funct3;
   assign dec.altOp  = instr.rType.funct7[5];   // Instruction bit 30
   assign dec.regOp  = instr.rType.opcode[5];   // 1 for ADD/SUB and 0 for ADDI

   // Each immediate from its own format view
   assign dec.immI = {{(xlen-12){instr.iType.imm[11]}}, instr.iType.imm};
   assign dec.immS = {{(xlen-12){instr.sType.immHi[6]}}, instr.sType.immHi, instr.sType.immLo};
   assign dec.immB = {{(xlen-12){instr.bType.imm12}}, instr.bType.imm11,
                      instr.bType.imm10to5, instr.bType.imm4to1, 1'b0};
   assign dec.immU = {instr.uType.imm, 12'b0};   // Upper 20 bits
   assign dec.immJ = {{(xlen-20){instr.jType.imm20}}, instr.jType.imm19to12,
                      instr.jType.imm11, instr.jType.imm10to1, 1'b0};

endmodule

// File: source/memAlign.sv
`timescale 1ns/1ps

module memAlign import femtoPkg::*; (
   input  logic [1:0]      addrLow,     // Byte offset of the access
   input  coreState        state,
   input  logic [xlen-1:0] memRData,
   input  logic [xlen-1:0] rs2Data,
   input  logic [xlen-1:0] aluResult,
   input  logic [xlen-1:0] pcPlusImm,
   input  logic [xlen-1:0] pcPlus4,
   decodeIf.consumer       dec,
   output logic [xlen-1:0] memWData,
   output logic [3:0]      memWMask,
   output logic [xlen-1:0] wbData
);

   logic            byteAccess;
   logic            halfAccess;
   logic [15:0]     loadHalf;
   logic [7:0]      loadByte;
   logic            loadSign;
   logic [xlen-1:0] loadData;
   logic [3:0]      storeMask;

   assign byteAccess = (dec.funct3[1:0] == sizeByte);
   assign halfAccess = (dec.funct3[1:0] == sizeHalf);

   // ******************************
   // Load extraction
   assign loadHalf = addrLow[1] ? memRData[31:16] : memRData[15:0];
   assign loadByte = addrLow[0] ? loadHalf[15:8] : loadHalf[7:0];
   assign loadSign = !dec.funct3[2] & (byteAccess ? loadByte[7] : loadHalf[15]);   // LBU/LHU

   assign loadData = byteAccess ? {{24{loadSign}}, loadByte} :
                     halfAccess ? {{16{loadSign}}, loadHalf} : memRData;

   // ******************************
   // Store lanes carry copies of the low bytes
   assign memWData[7:0]   = rs2Data[7:0];
   assign memWData[15:8]  = addrLow[0] ? rs2Data[7:0] : rs2Data[15:8];
   assign memWData[23:16] = addrLow[1] ? rs2Data[7:0] : rs2Data[23:16];
   assign memWData[31:24] = addrLow[0] ? rs2Data[7:0] :
                            addrLow[1] ? rs2Data[15:8] : rs2Data[31:24];

   always_comb begin
      if (byteAccess) begin
         storeMask = 4'b0001 << addrLow;                  // One lane
      end else if (halfAccess) begin
         storeMask = addrLow[1] ? 4'b1100 : 4'b0011;      // Upper or lower half
      end else begin
         storeMask = 4'b1111;
      end
   end

   assign memWMask = (state == store) ? storeMask : 4'b0000;   // Only in the store cycle

   // ******************************
   // Write-back sources are exclusive so an OR selects
   assign wbData = (dec.isLui                  ? dec.immU  : '0) |
                   ((dec.isAluImm | dec.isAluReg) ? aluResult : '0) |
                   (dec.isAuipc                ? pcPlusImm : '0) |
                   ((dec.isJal | dec.isJalr)   ? pcPlus4   : '0) |   // Link value
                   (dec.isLoad                 ? loadData  : '0);

endmodule

// File: source/regFile.sv
`timescale 1ns/1ps

module regFile import femtoPkg::*; (
   input  logic                    clk,
   input  logic [regAddrWidth-1:0] rs1,
   input  logic [regAddrWidth-1:0] rs2,
   input  logic [regAddrWidth-1:0] rd,
   input  logic                    wbEnable,
   input  logic [xlen-1:0]         wbData,
   output logic [xlen-1:0]         rs1Data,   // Valid one cycle after the index
   output logic [xlen-1:0]         rs2Data
);

   logic [xlen-1:0] regs [2**regAddrWidth];

   // Both ports read every cycle and x0 always reads as zero
   always_ff @(posedge clk) begin
      rs1Data <= (rs1 == '0) ? '0 : regs[rs1];
      rs2Data <= (rs2 == '0) ? '0 : regs[rs2];
   end

   always_ff @(posedge clk) begin
      if (wbEnable && (rd != '0)) begin
         regs[rd] <= wbData;   // x0 stays unwritten
      end
   end

endmodule

// File: tests/clockGen.sv
`timescale 1ns/1ps

module clockGen #(
   parameter int periodNs = 8
) (
   output logic clk
);

   initial begin
      clk = 1'b0;
   end

   always #(periodNs / 2.0) clk = ~clk;   // Free running

endmodule

// File: tests/femtoCoreSva.sv
`timescale 1ns/1ps

module femtoCoreSva import femtoPkg::*; (
   input logic       clk,
   input logic       reset,
   input logic       memRead,
   input logic [3:0] memWMask,
   input coreState   state
);

   int failCount = 0;   // Failed assertions so far

   // Read strobe and write mask never overlap
   readWriteApart: assert property (@(posedge clk) disable iff (!reset)
      !(memRead && (memWMask != 4'b0000)))
      else begin
         $error("memRead and memWMask active together");
         failCount++;
      end

   // Byte, halfword or word lanes only
   legalMask: assert property (@(posedge clk) disable iff (!reset)
      memWMask inside {4'b0000, 4'b0001, 4'b0010, 4'b0100, 4'b1000,
                       4'b0011, 4'b1100, 4'b1111})
      else begin
         $error("memWMask has an illegal lane pattern");
         failCount++;
      end

   storeOneCycle: assert property (@(posedge clk) disable iff (!reset)
      (state == store) |=> (state != store))
      else begin
         $error("store state held longer than one cycle");
         failCount++;
      end

endmodule

bind femtoCore femtoCoreSva sva0 (
   .clk(clk), .reset(reset), .memRead(memRead), .memWMask(memWMask), .state(state)
);

// File: tests/femtoCoreTb.sv
`timescale 1ns/1ps

module femtoCoreTb;

   localparam int periodNs  = 8;
   localparam int bodyLen   = 200;            // Random instructions
   localparam int bodyStart = 31;             // After the register preload
   localparam int dumpStart = bodyStart + bodyLen;
   localparam int selfIdx   = dumpStart + 32; // Jump-to-self
   localparam logic [31:0] selfJump = 32'h0000_006F;
   // Per instruction a base budget plus the longest shift and busy stalls
   localparam longint timeLimit = longint'(selfIdx + 1) * (20 + 31 + 8) * periodNs;

   logic        clk;
   logic        reset;
   logic [31:0] memAddr;
   logic [31:0] memWData;
   logic [3:0]  memWMask;
   logic [31:0] memRData;
   logic        memRead;
   logic        memRBusy;
   logic        memWBusy;

   logic [31:0] mem [1024];          // 4 KB memory model
   logic [31:0] modelMem [1024];     // Reference copy
   logic [31:0] readQ [$];           // Expected fetch and load addresses
   logic [31:0] stAddrQ [$];
   logic [3:0]  stMaskQ [$];
   logic [31:0] stDataQ [$];
   int          errors = 0;
   logic        done = 1'b0;

   clockGen #(.periodNs(periodNs)) clock0 (.clk(clk));

   femtoCore #(.resetAddr(32'h0), .addrWidth(24)) dut0 (
      .clk(clk), .reset(reset), .memAddr(memAddr), .memWData(memWData),
      .memWMask(memWMask), .memRData(memRData), .memRead(memRead),
      .memRBusy(memRBusy), .memWBusy(memWBusy)
   );

   // ******************************
   task automatic checkValue(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
      if (expected !== actual) begin
         $display("ERROR at %0t: %s expected %h got %h", $time, name, expected, actual);
         errors++;
      end
   endtask

   // Instruction encoders
   function automatic logic [31:0] encI(input logic [11:0] imm, input logic [4:0] rs1,
                                        input logic [2:0] f3, input logic [4:0] rd,
                                        input logic [6:0] op);
      return {imm, rs1, f3, rd, op};
   endfunction

   function automatic logic [31:0] encR(input logic [6:0] f7, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3,
                                        input logic [4:0] rd);
      return {f7, rs2, rs1, f3, rd, 7'h33};
   endfunction

   function automatic logic [31:0] encS(input logic [11:0] imm, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3);
      return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'h23};
   endfunction

   function automatic logic [31:0] encB(input logic [12:0] imm, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3);
      return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'h63};
   endfunction

   function automatic logic [31:0] encJ(input logic [20:0] imm, input logic [4:0] rd);
      return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'h6F};
   endfunction

   // ******************************
   task automatic buildProgram();
      int          k;
      int          f3;
      logic [31:0] ins;
      logic [11:0] off;
      for (int i = 0; i < 1024; i++) begin
         mem[i] = (i * 32'h9E37_79B9) ^ 32'hA5C3_0F1E;   // Fill from the whole address
      end
      for (int i = 1; i < 30; i++) begin
         mem[i - 1] = encI(12'($urandom), 5'd0, 3'd0, 5'(i), 7'h13);
      end
      mem[29] = {20'h0, 5'd30, 7'h37};   // x30 = 0 for JALR
      mem[30] = {20'h1, 5'd31, 7'h37};   // x31 = 0x1000 data base
      for (int idx = bodyStart; idx < dumpStart; idx++) begin
         k = $urandom_range(1, (dumpStart - idx < 4) ? dumpStart - idx : 4);   // Forward hop
         case ($urandom_range(0, 9))
            0: ins = {20'($urandom), 5'($urandom_range(0, 29)), 7'h37};
            1: ins = {20'($urandom), 5'($urandom_range(0, 29)), 7'h17};
            2: ins = encJ(21'(4 * k), 5'($urandom_range(0, 29)));
            3: ins = encI(12'(4 * (idx + k)), 5'd30, 3'd0, 5'($urandom_range(0, 29)), 7'h67);
            4: begin
               f3 = $urandom_range(0, 5);
               f3 = (f3 < 2) ? f3 : f3 + 2;                  // 0 1 4 5 6 7
               ins = encB(13'(4 * k), 5'($urandom), 5'($urandom), 3'(f3));
            end
            5: begin
               f3 = $urandom_range(0, 4);
               f3 = (f3 < 3) ? f3 : f3 + 1;                  // LB LH LW LBU LHU
               off = 12'(-1024 + $urandom_range(0, 511));
               off = (f3[1:0] == 2) ? off & ~12'd3 : (f3[0] ? off & ~12'd1 : off);
               ins = encI(off, 5'd31, 3'(f3), 5'($urandom_range(0, 29)), 7'h03);
            end
            6: begin
               f3 = $urandom_range(0, 2);
               off = 12'(-1024 + $urandom_range(0, 511));
               off = (f3 == 2) ? off & ~12'd3 : ((f3 == 1) ? off & ~12'd1 : off);
               ins = encS(off, 5'($urandom), 5'd31, 3'(f3));
            end
            7: begin
               f3 = $urandom_range(0, 7);
               off = 12'($urandom);
               if (f3 == 1) off = {7'b0, off[4:0]};                     // SLLI
               if (f3 == 5) off = {1'b0, off[10], 5'b0, off[4:0]};      // SRLI or SRAI
               ins = encI(off, 5'($urandom), 3'(f3), 5'($urandom_range(0, 29)), 7'h13);
            end
            default: begin
               f3 = $urandom_range(0, 7);
               ins = encR(((f3 == 0) || (f3 == 5)) ? {1'b0, 1'($urandom), 5'b0} : 7'b0,
                          5'($urandom), 5'($urandom), 3'(f3), 5'($urandom_range(0, 29)));
            end
         endcase
         mem[idx] = ins;
      end
      for (int i = 0; i < 32; i++) begin
         mem[dumpStart + i] = encS(12'(-512 + 4 * i), 5'(i), 5'd31, 3'd2);   // Dump x0 to x31
      end
      mem[selfIdx] = selfJump;
      modelMem = mem;
   endtask

   function automatic logic [31:0] aluModel(input logic [2:0] f3, input logic alt,
                                            input logic isReg, input logic [31:0] a,
                                            input logic [31:0] b);
      case (f3)
         3'd0: return (alt && isReg) ? a - b : a + b;
         3'd1: return a << b[4:0];
         3'd2: return {31'b0, $signed(a) < $signed(b)};
         3'd3: return {31'b0, a < b};
         3'd4: return a ^ b;
         3'd5: return alt ? 32'($signed(a) >>> b[4:0]) : a >> b[4:0];
         3'd6: return a | b;
         default: return a & b;
      endcase
   endfunction

   // ******************************
   // Reference model of RV32I
   task automatic runModel();
      logic [31:0] r [32];
      logic [31:0] pc;
      logic [31:0] nextPc;
      logic [31:0] ins;
      logic [31:0] res;
      logic [31:0] a;
      logic [31:0] b;
      logic [31:0] ea;
      logic [31:0] immI;
      logic [31:0] w;
      logic [3:0]  m;
      logic        wr;
      logic        taken;
      r = '{default: 32'h0};
      pc = 32'h0;
      for (int n = 0; n < 5000; n++) begin
         readQ.push_back(pc);
         ins = modelMem[pc[11:2]];
         if (ins == selfJump) break;
         a = r[ins[19:15]];
         b = r[ins[24:20]];
         immI = {{20{ins[31]}}, ins[31:20]};
         nextPc = pc + 4;
         wr = 1'b1;
         res = 32'h0;
         case (ins[6:0])
            7'h37: res = {ins[31:12], 12'h0};
            7'h17: res = pc + {ins[31:12], 12'h0};
            7'h6F: begin
               res = pc + 4;
               nextPc = pc + {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
            end
            7'h67: begin
               res = pc + 4;
               nextPc = (a + immI) & ~32'd1;
            end
            7'h63: begin
               wr = 1'b0;
               case (ins[14:12])
                  3'd0: taken = (a == b);
                  3'd1: taken = (a != b);
                  3'd4: taken = ($signed(a) < $signed(b));
                  3'd5: taken = ($signed(a) >= $signed(b));
                  3'd6: taken = (a < b);
                  default: taken = (a >= b);
               endcase
               if (taken) nextPc = pc + {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
            end
            7'h03: begin
               ea = a + immI;
               readQ.push_back(ea);
               w = modelMem[ea[11:2]] >> (8 * ea[1:0]);
               case (ins[14:12])
                  3'd0: res = {{24{w[7]}}, w[7:0]};
                  3'd1: res = {{16{w[15]}}, w[15:0]};
                  3'd4: res = {24'h0, w[7:0]};
                  3'd5: res = {16'h0, w[15:0]};
                  default: res = w;
               endcase
            end
            7'h23: begin
               wr = 1'b0;
               ea = a + {{20{ins[31]}}, ins[31:25], ins[11:7]};
               m = (ins[14:12] == 3'd0) ? 4'b0001 : ((ins[14:12] == 3'd1) ? 4'b0011 : 4'b1111);
               m = m << ea[1:0];
               w = b << (8 * ea[1:0]);   // Data in its lanes
               stAddrQ.push_back(ea);
               stMaskQ.push_back(m);
               stDataQ.push_back(w);
               for (int l = 0; l < 4; l++) begin
                  if (m[l]) modelMem[ea[11:2]][8*l +: 8] = w[8*l +: 8];
               end
            end
            7'h13: res = aluModel(ins[14:12], ins[30], 1'b0, a, immI);
            default: res = aluModel(ins[14:12], ins[30], 1'b1, a, b);
         endcase
         if (wr && (ins[11:7] != 5'd0)) r[ins[11:7]] = res;
         pc = nextPc;
      end
   endtask

   // ******************************
   // Memory model with random busy levels
   always @(posedge clk) begin
      static int rLeft = 0;
      static int wLeft = 0;
      logic [31:0] rNext;
      logic        rHit;
      rHit = memRead;
      rNext = mem[memAddr[11:2]];
      for (int l = 0; l < 4; l++) begin
         if (memWMask[l]) mem[memAddr[11:2]][8*l +: 8] = memWData[8*l +: 8];
      end
      #1;
      if (rHit) memRData = rNext;   // Answer on the next cycle
      if (rLeft > 0) begin
         rLeft--;
      end else if ($urandom_range(0, 3) == 0) begin
         rLeft = $urandom_range(1, 2);
      end
      if (wLeft > 0) begin
         wLeft--;
      end else if ($urandom_range(0, 3) == 0) begin
         wLeft = $urandom_range(1, 2);
      end
      memRBusy = (rLeft > 0);
      memWBusy = (wLeft > 0);
   end

   // Access monitor against the model lists
   always @(posedge clk) begin
      logic [31:0] lanes;
      if (reset && !done) begin
         if (memRead) begin
            checkValue("memAddr", readQ.pop_front(), memAddr);
            if (readQ.size() == 0) done = 1'b1;   // Self jump fetched
         end
         if (memWMask != 4'b0000) begin
            if (stAddrQ.size() == 0) begin
               $display("Store seen that the model does not expect");
               errors++;
            end else begin
               lanes = {{8{memWMask[3]}}, {8{memWMask[2]}}, {8{memWMask[1]}}, {8{memWMask[0]}}};
               checkValue("memAddr", stAddrQ.pop_front(), memAddr);
               checkValue("memWMask", 32'(stMaskQ.pop_front()), 32'(memWMask));
               checkValue("memWData", stDataQ.pop_front() & lanes, memWData & lanes);
            end
         end
      end
   end

   // ******************************
   initial begin
      reset = 1'b0;
      memRBusy = 1'b0;
      memWBusy = 1'b0;
      memRData = 32'h0;
      void'($urandom(32'h4343_dc8c));
      buildProgram();
      runModel();
      repeat (2) @(posedge clk);
      #1 reset = 1'b1;
      wait (done);
      repeat (20) @(posedge clk);
      checkValue("storesLeft", 32'h0, 32'(stAddrQ.size()));
      for (int i = 768; i < 1024; i++) begin
         checkValue($sformatf("mem[%0d]", i), modelMem[i], mem[i]);   // Data and dump area
      end
      errors = errors + dut0.sva0.failCount;   // Bound assertion failures
      $display("Errors: %0d", errors);
      if (errors == 0) begin
         $display("Finished with no errors");
      end else begin
         $display("Finished with errors");
      end
      $finish;
   end

   // Watchdog
   initial begin
      #(timeLimit);
      $display("Timeout: the core did not reach the end of the program in time");
      $display("Errors: %0d", errors + dut0.sva0.failCount + 1);
      $display("Finished with errors");
      $finish;
   end

endmodule
